// File: src.f
+incdir+verilog
verilog/common_pkg.sv
verilog/wb_if.sv
verilog/wb_mux.sv
verilog/wb_bus_ctrl.sv
verilog/wb_ram.sv
verilog/wb_regs.sv
verilog/host_port.sv
verilog/video_fetch.sv
verilog/pet_bus_top.sv
bench/pet_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module pet_bus_tb -o pet_bus_sim
./obj_dir/pet_bus_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "Run finished without errors"
else
    echo "Run reported errors, see sim.log"
    exit 1
fi

// File: bench/bus_stimulus.txt
# op addr data expect, all hex; W writes, R reads and checks expect
# V with addr 1 or 0 switches video fetch; D waits addr cycles
R 8005 00 00
R 8001 00 00
W 03ff 5a 00
R 03ff 00 5a
W 0000 10 00
W 0001 21 00
W 0002 32 00
W 0003 43 00
W 0004 54 00
W 0005 65 00
W 0006 76 00
W 0007 87 00
W 0008 98 00
W 0009 a9 00
W 000a ba 00
W 000b cb 00
W 000c dc 00
W 000d ed 00
W 000e fe 00
W 000f 0f 00
R 0000 00 10
W 8002 c3 00
R 8002 00 c3
R 0002 00 32
V 0001 00 00
D 0080 00 00
R 0005 00 65
W 8007 7e 00
R 8007 00 7e
W 0200 99 00
R 0200 00 99
R 000f 00 0f
R 03ff 00 5a
V 0000 00 00
D 0010 00 00
V 0001 00 00
D 0040 00 00
R 0000 00 10
V 0000 00 00
D 0010 00 00
R 8007 00 7e

// File: bench/pet_bus_tb.sv
`include "common_macros.svh"

module pet_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                      wb_clock;
    logic                      rst;
    logic                      host_req;
    logic                      host_we;
    logic [`WB_ADDR_WIDTH-1:0] host_addr;
    logic [`DATA_WIDTH-1:0]    host_wdata;
    logic [`DATA_WIDTH-1:0]    host_rdata;
    logic                      host_done;
    logic                      host_busy;
    logic                      video_en;
    logic [`DATA_WIDTH-1:0]    video_pix;
    logic                      video_valid;

    logic [7:0]                op_kind [$];             // W, R, V or D
    logic [`WB_ADDR_WIDTH-1:0] op_addr [$];             // Address, flag or wait count
    logic [`DATA_WIDTH-1:0]    op_data [$];
    logic [`DATA_WIDTH-1:0]    op_exp  [$];             // Expected read data
    logic [`DATA_WIDTH-1:0]    ram_ref [`RAM_DEPTH];    // Shadow of host RAM writes
    logic [9:0]                vexp;                    // Predicted video address
    logic                      started;                 // First stimulus issued
    integer                    seed;
    int n_ops, cycles, cycle_limit, pix_count, host_checks;
    int host_errors, video_errors, other_errors;

    pet_bus_top dut_i (
        .wb_clock_i    (wb_clock),
        .rst_i         (rst),
        .host_req_i    (host_req),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_rdata_o  (host_rdata),
        .host_done_o   (host_done),
        .host_busy_o   (host_busy),
        .video_en_i    (video_en),
        .video_pix_o   (video_pix),
        .video_valid_o (video_valid)
    );

    always #5 wb_clock = ~wb_clock;                     // 10 ns period

    // Parse the stimulus file into the op queues
    task automatic load_stimulus();
        int                        fd;
        int                        n;
        string                     line;
        logic [7:0]                kind;
        logic [`WB_ADDR_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0]    d;
        logic [`DATA_WIDTH-1:0]    e;
        fd = $fopen("bench/bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/bus_stimulus.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;   // Blank or column notes
            n = $sscanf(line, "%c %h %h %h", kind, a, d, e);
            if (n != 4) begin
                $display("Malformed stimulus line: %s", line);
                other_errors++;
                continue;
            end
            op_kind.push_back(kind);
            op_addr.push_back(a);
            op_data.push_back(d);
            op_exp.push_back(e);
        end
        $fclose(fd);
    endtask

    // One host transfer, entered and left on a falling edge
    task automatic host_op(input logic we, input logic [`WB_ADDR_WIDTH-1:0] a,
                           input logic [`DATA_WIDTH-1:0] d, input logic [`DATA_WIDTH-1:0] e);
        int gap;
        host_we    = we;
        host_addr  = a;
        host_wdata = d;
        host_req   = 1'b1;
        @(negedge wb_clock);
        host_req = 1'b0;                                // Single-cycle request pulse
        while (host_done !== 1'b1) @(negedge wb_clock);
        if (we) begin
            if (!a[`WB_ADDR_WIDTH-1]) ram_ref[a[9:0]] = d;   // Select bit low is RAM
        end else begin
            host_checks++;
            if (host_rdata !== e) begin
                $display("FAILED at %0t: host read of %h returned %h, expected %h",
                         $time, a, host_rdata, e);
                host_errors++;
            end
        end
        while (host_busy !== 1'b0) @(negedge wb_clock); // Port free again
        gap = $random(seed) & 3;
        repeat (gap) @(negedge wb_clock);
    endtask

    initial begin
        logic [7:0]                kind;
        logic [`WB_ADDR_WIDTH-1:0] a;
        wb_clock   = 1'b0;
        rst        = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        video_en   = 1'b0;
        started    = 1'b0;
        vexp       = '0;
        ram_ref    = '{default: '0};
        seed       = 32'h7464ed47;
        cycles = 0;
        pix_count = 0;
        host_checks = 0;
        host_errors = 0;
        video_errors = 0;
        other_errors = 0;
        cycle_limit = 2000;
        load_stimulus();
        n_ops = op_kind.size();
        cycle_limit = 40 * n_ops + 2000;                // Scaled to the stimulus length
        repeat (10) @(posedge wb_clock);
        @(negedge wb_clock);
        rst = 1'b0;
        repeat (5) @(negedge wb_clock);                 // Idle outputs watched here
        started = 1'b1;
        while (op_kind.size() > 0) begin
            kind = op_kind.pop_front();
            a    = op_addr.pop_front();
            case (kind)
                "W", "R": host_op(kind == "W", a, op_data.pop_front(), op_exp.pop_front());
                "V": begin
                    void'(op_data.pop_front());
                    void'(op_exp.pop_front());
                    video_en = a[0];
                    if (a[0]) vexp = '0;                // New pass starts at byte 0
                    @(negedge wb_clock);
                end
                default: begin
                    void'(op_data.pop_front());
                    void'(op_exp.pop_front());
                    if (kind != "D") begin
                        $display("Unknown stimulus op %c", kind);
                        other_errors++;
                    end
                    repeat (a) @(negedge wb_clock);
                end
            endcase
        end
        video_en = 1'b0;
        repeat (20) @(negedge wb_clock);                // Drain last video byte
        if (pix_count <= 2 * `VIDEO_LEN) begin
            $display("Video stream delivered only %0d bytes", pix_count);
            other_errors++;
        end
        $display("Host reads %0d, host errors %0d, video bytes %0d, video errors %0d, other errors %0d",
                 host_checks, host_errors, pix_count, video_errors, other_errors);
        if (host_errors + video_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Video scoreboard and idle check, sampled between edges
    always @(negedge wb_clock) begin
        if (!rst && !started &&
            (host_done !== 1'b0 || host_busy !== 1'b0 || video_valid !== 1'b0)) begin
            $display("FAILED at %0t: outputs active after reset before any stimulus", $time);
            other_errors++;
        end
        if (video_valid === 1'b1) begin
            pix_count++;
            if (video_pix !== ram_ref[vexp]) begin
                $display("FAILED at %0t: video byte %0d is %h, expected %h",
                         $time, vexp, video_pix, ram_ref[vexp]);
                video_errors++;
            end
            vexp = (vexp == 10'(`VIDEO_LEN - 1)) ? '0 : vexp + 10'd1;   // Looping address
        end
    end

    always @(posedge wb_clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a bus handshake never completed", cycles);
            $display("Simulation failed");
            $finish;
        end
    end
endmodule

// File: verilog/pet_bus_top.sv
`include "common_macros.svh"

module pet_bus_top (
    input  logic                      wb_clock_i,     // Clock
    input  logic                      rst_i,          // Sync reset
    input  logic                      host_req_i,     // Host request pulse
    input  logic                      host_we_i,      // Host write
    input  logic [`WB_ADDR_WIDTH-1:0] host_addr_i,    // Host address
    input  logic [`DATA_WIDTH-1:0]    host_wdata_i,   // Host write data
    output logic [`DATA_WIDTH-1:0]    host_rdata_o,   // Host read data
    output logic                      host_done_o,    // Host transfer done
    output logic                      host_busy_o,    // Host request pending
    input  logic                      video_en_i,     // Video fetch enable
    output logic [`DATA_WIDTH-1:0]    video_pix_o,    // Screen byte
    output logic                      video_valid_o   // Screen byte strobe
);
    logic [$clog2(`WB_CC)-1:0] wbc_sel;
    logic [$clog2(`WB_PC)-1:0] wbp_sel;

    wb_if wbc[`WB_CC] ();   // 0 host, 1 video
    wb_if wbp[`WB_PC] ();   // 0 RAM, 1 registers

    host_port u_host (
        .wb_clock_i (wb_clock_i),
        .rst_i      (rst_i),
        .req_i      (host_req_i),
        .we_i       (host_we_i),
        .addr_i     (host_addr_i),
        .wdata_i    (host_wdata_i),
        .rdata_o    (host_rdata_o),
        .done_o     (host_done_o),
        .busy_o     (host_busy_o),
        .bus        (wbc[0])
    );

    video_fetch u_video (
        .wb_clock_i  (wb_clock_i),
        .rst_i       (rst_i),
        .en_i        (video_en_i),
        .pix_o       (video_pix_o),
        .pix_valid_o (video_valid_o),
        .bus         (wbc[1])
    );

    wb_bus_ctrl u_ctrl (
        .wb_clock_i  (wb_clock_i),
        .rst_i       (rst_i),
        .controllers (wbc),
        .wbc_sel_o   (wbc_sel),
        .wbp_sel_o   (wbp_sel)
    );

    wb_mux u_mux (
        .controllers (wbc),
        .peripherals (wbp),
        .wbc_sel_i   (wbc_sel),
        .wbp_sel_i   (wbp_sel)
    );

    wb_ram u_ram (
        .wb_clock_i (wb_clock_i),
        .rst_i      (rst_i),
        .bus        (wbp[0])
    );

    wb_regs u_regs (
        .wb_clock_i (wb_clock_i),
        .rst_i      (rst_i),
        .bus        (wbp[1])
    );
endmodule

// File: verilog/video_fetch.sv
`include "common_macros.svh"

module video_fetch (
    input  logic                   wb_clock_i,     // Clock
    input  logic                   rst_i,          // Sync reset
    input  logic                   en_i,           // Fetch enable
    output logic [`DATA_WIDTH-1:0] pix_o,          // Fetched screen byte
    output logic                   pix_valid_o,    // Pulses with each byte
    wb_if.controller               bus             // Wishbone controller port
);
    localparam int VW = $clog2(`VIDEO_LEN);

    logic [VW-1:0] vaddr;                          // Screen byte counter

    assign bus.addr  = `WB_ADDR_WIDTH'(vaddr);     // Select bit 0, RAM
    assign bus.we    = 1'b0;                       // Read only
    assign bus.wdata = '0;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            bus.cycle   <= 1'b0;
            bus.strobe  <= 1'b0;
            vaddr       <= '0;
            pix_valid_o <= 1'b0;
        end else begin
            pix_valid_o <= 1'b0;
            if (bus.cycle) begin
                if (bus.strobe && !bus.stall) begin
                    bus.strobe <= 1'b0;
                end
                if (bus.ack) begin
                    bus.cycle   <= 1'b0;
                    pix_valid_o <= 1'b1;
                    if (!en_i || vaddr == VW'(`VIDEO_LEN - 1)) begin
                        vaddr <= '0;               // Wrap, or restart next pass
                    end else begin
                        vaddr <= vaddr + 1'b1;
                    end
                end
            end else if (en_i) begin
                bus.cycle  <= 1'b1;                // Next byte
                bus.strobe <= 1'b1;
            end else begin
                vaddr <= '0;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (bus.cycle && bus.ack) begin
            pix_o <= bus.rdata;
        end
    end
endmodule

// File: verilog/host_port.sv
`include "common_macros.svh"

module host_port (
    input  logic                      wb_clock_i,   // Clock
    input  logic                      rst_i,        // Sync reset
    input  logic                      req_i,        // Request pulse
    input  logic                      we_i,         // Write when high
    input  logic [`WB_ADDR_WIDTH-1:0] addr_i,       // Request address
    input  logic [`DATA_WIDTH-1:0]    wdata_i,      // Write data
    output logic [`DATA_WIDTH-1:0]    rdata_o,      // Read data, valid with done_o
    output logic                      done_o,       // Transfer finished
    output logic                      busy_o,       // Request in flight
    wb_if.controller                  bus           // Wishbone controller port
);
    logic start;                                    // Accept a new request

    assign start = req_i && !busy_o;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            busy_o     <= 1'b0;
            done_o     <= 1'b0;
            bus.cycle  <= 1'b0;
            bus.strobe <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start) begin
                busy_o     <= 1'b1;
                bus.cycle  <= 1'b1;
                bus.strobe <= 1'b1;
            end else if (done_o) begin
                busy_o <= 1'b0;                     // Ready again after done pulse
            end else if (bus.cycle) begin
                if (bus.strobe && !bus.stall) begin
                    bus.strobe <= 1'b0;             // Accepted, single transfer
                end
                if (bus.ack) begin
                    bus.cycle <= 1'b0;
                    done_o    <= 1'b1;
                end
            end
        end
    end

    // Request latch and read capture
    always_ff @(posedge wb_clock_i) begin
        if (start) begin
            bus.we    <= we_i;
            bus.addr  <= addr_i;
            bus.wdata <= wdata_i;
        end
        if (bus.cycle && bus.ack) begin
            rdata_o <= bus.rdata;
        end
    end

    // Done comes after the bus cycle closed, still inside busy
    assert property (@(posedge wb_clock_i) disable iff (rst_i)
        done_o |-> busy_o && !bus.cycle);
endmodule

// File: verilog/wb_regs.sv
`include "common_macros.svh"

module wb_regs (
    input  logic      wb_clock_i,   // Clock
    input  logic      rst_i,        // Sync reset
    wb_if.peripheral  bus           // Wishbone peripheral port
);
    localparam int RW = $clog2(`REG_COUNT);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];  // Control registers
    common_pkg::wb_addr_u   a;
    logic [RW-1:0]          idx;                // Register number
    logic                   req;                // Strobe present
    logic                   primed;             // First cycle already stalled
    logic                   acc;                // Strobe accepted this edge

    assign a.raw     = bus.addr;
    assign idx       = a.f.offset[RW-1:0];
    assign req       = bus.cycle && bus.strobe;
    assign bus.stall = req && !primed;          // Stall first cycle of a strobe
    assign acc       = req && primed;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            primed  <= 1'b0;
            bus.ack <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            primed  <= req && !primed;          // Clears on accept or dropped cycle
            bus.ack <= acc;
            if (acc && bus.we) begin
                regs[idx] <= bus.wdata;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (acc) begin
            bus.rdata <= regs[idx];
        end
    end

    // Controller drops strobe on acceptance, so ack never meets a stall
    assert property (@(posedge wb_clock_i) disable iff (rst_i)
        !(bus.stall && bus.ack));
endmodule

// File: verilog/wb_ram.sv
`include "common_macros.svh"

module wb_ram (
    input  logic      wb_clock_i,   // Clock
    input  logic      rst_i,        // Sync reset
    wb_if.peripheral  bus           // Wishbone peripheral port
);
    localparam int AW = $clog2(`RAM_DEPTH);

    logic [`DATA_WIDTH-1:0] mem [`RAM_DEPTH];   // Screen and work RAM
    common_pkg::wb_addr_u   a;
    logic [AW-1:0]          idx;                // Byte index
    logic                   acc;                // Strobe accepted this edge

    assign a.raw     = bus.addr;
    assign idx       = a.f.offset[AW-1:0];
    assign bus.stall = 1'b0;                    // Always ready
    assign acc       = bus.cycle && bus.strobe;

    always_ff @(posedge wb_clock_i) begin
        if (acc) begin
            if (bus.we) begin
                mem[idx] <= bus.wdata;
            end
            bus.rdata <= mem[idx];              // Old value on a write
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= acc;                     // One cycle after acceptance
        end
    end

    // Ack answers a strobe of a cycle that is still open
    assert property (@(posedge wb_clock_i) disable iff (rst_i)
        bus.ack |-> bus.cycle);
endmodule

// File: verilog/wb_bus_ctrl.sv
`include "common_macros.svh"

module wb_bus_ctrl (
    input  logic                      wb_clock_i,           // Clock
    input  logic                      rst_i,                // Sync reset
    wb_if.monitor                     controllers[`WB_CC],  // Controller requests
    output logic [$clog2(`WB_CC)-1:0] wbc_sel_o,            // Granted controller
    output logic [$clog2(`WB_PC)-1:0] wbp_sel_o             // Decoded peripheral
);
    localparam int CW = $clog2(`WB_CC);
    localparam int PW = $clog2(`WB_PC);
    // Park on the register file while idle, its first-cycle stall holds requesters off
    localparam logic [PW-1:0] PARK = PW'(`WB_PC - 1);

    logic [`WB_CC-1:0]                     cyc;
    logic [`WB_CC-1:0][`WB_ADDR_WIDTH-1:0] addr;
    logic                                  busy;      // Grant active
    logic [CW-1:0]                         req_sel;   // Next controller to serve
    common_pkg::wb_addr_u                  req_addr;  // Its address, decoded

    for (genvar c = 0; c < `WB_CC; c++) begin : g_mon
        assign cyc[c]  = controllers[c].cycle;
        assign addr[c] = controllers[c].addr;
    end

    // Round-robin, wbc_sel_o keeps the last served controller after release
    always_comb begin
        req_sel = wbc_sel_o;
        for (int i = `WB_CC; i >= 1; i--) begin           // Nearest after last wins
            if (cyc[(int'(wbc_sel_o) + i) % `WB_CC]) begin
                req_sel = CW'((int'(wbc_sel_o) + i) % `WB_CC);
            end
        end
    end

    assign req_addr.raw = addr[req_sel];

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            busy      <= 1'b0;
            wbc_sel_o <= CW'(`WB_CC - 1);                   // Controller 0 first
            wbp_sel_o <= PARK;
        end else if (!busy) begin
            if (|cyc) begin                                 // Grant at next edge
                busy      <= 1'b1;
                wbc_sel_o <= req_sel;
                wbp_sel_o <= PW'(req_addr.f.psel);
            end
        end else if (!cyc[wbc_sel_o]) begin                 // Cycle dropped, release
            busy      <= 1'b0;
            wbp_sel_o <= PARK;
        end
    end

    // Grant only goes to a controller still holding its cycle
    assert property (@(posedge wb_clock_i) disable iff (rst_i)
        $rose(busy) |-> cyc[wbc_sel_o]);

    // Target peripheral matches the granted address for the whole cycle
    assert property (@(posedge wb_clock_i) disable iff (rst_i)
        busy && cyc[wbc_sel_o] |-> wbp_sel_o == PW'(addr[wbc_sel_o][`WB_ADDR_WIDTH-1]));
endmodule

// File: verilog/wb_mux.sv
`include "common_macros.svh"

module wb_mux #(
    parameter int CC = `WB_CC,                // Number of controllers
    parameter int PC = `WB_PC                 // Number of peripherals
) (
    wb_if.peripheral             controllers[CC],  // Controller side ports
    wb_if.controller             peripherals[PC],  // Peripheral side ports
    input  logic [$clog2(CC)-1:0] wbc_sel_i,       // Selected controller
    input  logic [$clog2(PC)-1:0] wbp_sel_i        // Selected peripheral
);
    logic [CC-1:0]                     c_cyc, c_stb, c_we, c_stall, c_ack;
    logic [CC-1:0][`WB_ADDR_WIDTH-1:0] c_addr;
    logic [CC-1:0][`DATA_WIDTH-1:0]    c_wdata, c_rdata;
    logic [PC-1:0]                     p_cyc, p_stb, p_we, p_stall, p_ack;
    logic [PC-1:0][`WB_ADDR_WIDTH-1:0] p_addr;
    logic [PC-1:0][`DATA_WIDTH-1:0]    p_wdata, p_rdata;

    // Interface arrays only take constant indices, so flatten them
    for (genvar c = 0; c < CC; c++) begin : g_ctrl
        assign c_cyc[c]               = controllers[c].cycle;
        assign c_stb[c]               = controllers[c].strobe;
        assign c_we[c]                = controllers[c].we;
        assign c_addr[c]              = controllers[c].addr;
        assign c_wdata[c]             = controllers[c].wdata;
        assign controllers[c].rdata   = c_rdata[c];
        assign controllers[c].stall   = c_stall[c];
        assign controllers[c].ack     = c_ack[c];
    end

    for (genvar p = 0; p < PC; p++) begin : g_perip
        assign peripherals[p].cycle   = p_cyc[p];
        assign peripherals[p].strobe  = p_stb[p];
        assign peripherals[p].we      = p_we[p];
        assign peripherals[p].addr    = p_addr[p];
        assign peripherals[p].wdata   = p_wdata[p];
        assign p_rdata[p]             = peripherals[p].rdata;
        assign p_stall[p]             = peripherals[p].stall;
        assign p_ack[p]               = peripherals[p].ack;
    end

    always_comb begin
        c_rdata = '0;                                 // Idle controllers see stall
        c_stall = '1;
        c_ack   = '0;
        p_cyc   = '0;                                 // Idle peripherals see no cycle
        p_stb   = '0;
        p_we    = '0;
        p_addr  = '0;
        p_wdata = '0;
        p_cyc[wbp_sel_i]   = c_cyc[wbc_sel_i];
        p_stb[wbp_sel_i]   = c_stb[wbc_sel_i];
        p_we[wbp_sel_i]    = c_we[wbc_sel_i];
        p_addr[wbp_sel_i]  = c_addr[wbc_sel_i];
        p_wdata[wbp_sel_i] = c_wdata[wbc_sel_i];
        c_rdata[wbc_sel_i] = p_rdata[wbp_sel_i];
        c_stall[wbc_sel_i] = p_stall[wbp_sel_i];
        c_ack[wbc_sel_i]   = p_ack[wbp_sel_i];
    end
endmodule

// File: verilog/wb_if.sv
`include "common_macros.svh"

// Wishbone B4 signal bundle, one per controller or peripheral port
interface wb_if;
    logic                      cycle;   // Cycle request
    logic                      strobe;  // Strobe
    logic                      we;      // Write enable
    logic [`WB_ADDR_WIDTH-1:0] addr;    // Address bus
    logic [`DATA_WIDTH-1:0]    wdata;   // Data toward peripheral
    logic [`DATA_WIDTH-1:0]    rdata;   // Data toward controller
    logic                      stall;   // Stall
    logic                      ack;     // Acknowledge

    modport controller (
        output cycle, strobe, we, addr, wdata,
        input  rdata, stall, ack
    );

    modport peripheral (
        input  cycle, strobe, we, addr, wdata,
        output rdata, stall, ack
    );

    // Read-only view for the arbiter
    modport monitor (
        input cycle, strobe, we, addr, wdata, ack
    );
endinterface

// File: verilog/common_pkg.sv
`include "common_macros.svh"

package common_pkg;

    // One address word, seen raw or split into peripheral select and offset
    // Peripheral 0 is the RAM, peripheral 1 the register file
    typedef union packed {
        logic [`WB_ADDR_WIDTH-1:0] raw;                // Word as driven on the bus
        struct packed {
            logic                      psel;           // Target peripheral
            logic [`WB_ADDR_WIDTH-2:0] offset;         // Offset inside the target
        } f;
    } wb_addr_u;

endpackage

// File: verilog/common_macros.svh
`ifndef COMMON_MACROS_SVH
`define COMMON_MACROS_SVH

// Bus geometry
`define WB_ADDR_WIDTH 16      // Wishbone address bits
`define DATA_WIDTH    8       // Byte-wide data bus
`define WB_CC         2       // Controllers: host port, video fetch
`define WB_PC         2       // Peripherals: RAM, register file

// Peripheral sizes
`define RAM_DEPTH     1024    // Screen and work RAM bytes
`define REG_COUNT     8       // Control registers

// Video fetch
`define VIDEO_LEN     16      // Bytes per screen pass, from RAM address 0

`endif
